/* verilog/jsp_defines.svh */
// JTAG serial port sizing macros shared by the packages and the RTL

`ifndef JSP_DEFINES_SVH
`define JSP_DEFINES_SVH

// Width of one data byte on the serial link and the bus
`define JSP_BYTE_W 8

// Width of every byte count, wide enough to hold the full FIFO depth
`define JSP_CNT_W 4

// Bytes held in each direction
`define JSP_FIFO_DEPTH 8

`endif

/* verilog/jsp_jtag_pkg.sv */
// JTAG serial port JTAG-side types: TAP strobes, controller states, data words

`default_nettype none

`include "jsp_defines.svh"

package jsp_jtag_pkg;

  typedef logic [`JSP_BYTE_W-1:0] jsp_byte_t;  // One serial data byte
  typedef logic [`JSP_CNT_W-1:0]  jsp_cnt_t;   // Byte count or free space

  // TAP strobes for this module's data register, valid for one clock each
  typedef struct packed {
    logic capture;  // Capture-DR
    logic shift;    // Shift-DR, one data bit per clock
    logic update;   // Update-DR, ends a session
  } jsp_tap_t;

  // Input side, bits from the host into the rx FIFO
  typedef enum logic [1:0] {
    in_idle   = 2'd0,
    in_wait   = 2'd1,  // Waiting for the start bit
    in_counts = 2'd2,  // Taking the user count byte
    in_xfer   = 2'd3   // Taking data bytes
  } jsp_in_state_t;

  // Output side, tx FIFO bytes out to the host
  typedef enum logic [1:0] {
    out_idle   = 2'd0,
    out_counts = 2'd1,  // Shifting the status byte
    out_rdack  = 2'd2,  // First bit of a byte, pops the loaded byte
    out_xfer   = 2'd3   // Remaining bits of a byte
  } jsp_out_state_t;

endpackage

`default_nettype wire

/* verilog/jsp_bus_pkg.sv */
// JTAG serial port bus-side types: Wishbone request and response, FIFO status

`default_nettype none

`include "jsp_defines.svh"

package jsp_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone slave, classic single transfers
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;   // 1 = write
    logic                   adr;  // Register select
    logic [`JSP_BYTE_W-1:0] dat;  // Write data
  } jsp_wb_req_t;

  typedef struct packed {
    logic                   ack;  // Registered, one cycle per transfer
    logic [`JSP_BYTE_W-1:0] dat;  // Read data, valid with ack
  } jsp_wb_rsp_t;

  // Register map
  localparam logic JSP_ADR_DATA   = 1'b0;  // Write pushes tx, read pops rx
  localparam logic JSP_ADR_STATUS = 1'b1;  // {tx free, rx available}

  // FIFO levels as the JTAG side sees them, tx_avail lands in the high nibble
  typedef struct packed {
    logic [`JSP_CNT_W-1:0] tx_avail;  // Bytes waiting for the host
    logic [`JSP_CNT_W-1:0] rx_free;   // Room for host bytes
  } jsp_fifo_stat_t;

endpackage

`default_nettype wire

/* verilog/jsp_byte_fifo.sv */
// Byte FIFO: circular buffer with push, pop and occupancy count

`timescale 1ns/100ps
`default_nettype none

`include "jsp_defines.svh"

module jsp_byte_fifo
  import jsp_jtag_pkg::*;
(
  input  wire       tck_i,
  input  wire       rst_i,
  input  wire       push_i,   // Ignored when full
  input  jsp_byte_t data_i,
  input  wire       pop_i,    // Ignored when empty
  output jsp_byte_t data_o,   // Head byte, stale when empty
  output jsp_cnt_t  count_o
);

  localparam int PTR_W = $clog2(`JSP_FIFO_DEPTH);

  jsp_byte_t        mem_q [`JSP_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  jsp_cnt_t         count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i & (count_q != `JSP_CNT_W'(`JSP_FIFO_DEPTH));
  assign do_pop  = pop_i & (count_q != '0);

  // Storage
  always_ff @(posedge tck_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin  // Wrap at the last slot
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`JSP_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`JSP_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + jsp_cnt_t'(do_push) - jsp_cnt_t'(do_pop);  // Both at once, no change
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign count_o = count_q;

endmodule

`default_nettype wire

/* verilog/jsp_in_ctrl.sv */
// JTAG serial port input controller: deserializes tdi into rx FIFO pushes

`timescale 1ns/100ps
`default_nettype none

`include "jsp_defines.svh"

module jsp_in_ctrl
  import jsp_jtag_pkg::*;
#(
  parameter bit JSP_MULTI_DEVICE = 1'b1  // Wait for a 1 start bit, for shared chains
) (
  input  wire       tck_i,
  input  wire       rst_i,
  input  jsp_tap_t  tap_i,
  input  wire       module_select_i,
  input  wire       tdi_i,
  input  jsp_cnt_t  rx_free_i,   // FIFO space, sampled at capture
  output logic      rx_push_o,
  output jsp_byte_t rx_byte_o
);

  localparam int BIT_W = $clog2(`JSP_BYTE_W);

  jsp_in_state_t    state_q;
  jsp_in_state_t    state_d;
  logic [BIT_W-1:0] bit_cnt_q;    // Bits taken of the current byte
  logic             bit_max;      // Eighth bit of a byte on this edge
  jsp_byte_t        shreg_q;      // Deserializer, LSB arrives first
  jsp_byte_t        shreg_d;
  jsp_cnt_t         user_cnt_q;   // Bytes the host still intends to send
  jsp_cnt_t         space_cnt_q;  // Room left in the rx FIFO
  logic             sess_start;
  logic             shifting;     // Shift cycle while taking bits
  logic             accept;       // Completed byte goes to the FIFO

  assign sess_start = tap_i.capture & module_select_i;
  assign bit_max    = (bit_cnt_q == BIT_W'(`JSP_BYTE_W - 1));
  assign shreg_d    = {tdi_i, shreg_q[`JSP_BYTE_W-1:1]};  // New bit enters at the top
  assign shifting   = tap_i.shift & ((state_q == in_counts) | (state_q == in_xfer));

  // Throttle by both counts, extra host bytes are simply lost
  assign accept = (state_q == in_xfer) & tap_i.shift & bit_max
                & (user_cnt_q != '0) & (space_cnt_q != '0);

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      in_idle: begin
        if (sess_start) begin
          if (JSP_MULTI_DEVICE) begin
            state_d = in_wait;
          end else begin
            state_d = in_counts;
          end
        end
      end
      in_wait: begin
        if (tap_i.update) begin
          state_d = in_idle;
        end else if (tap_i.shift && tdi_i) begin
          state_d = in_counts;  // Start bit seen
        end
      end
      in_counts: begin
        if (tap_i.update) begin
          state_d = in_idle;
        end else if (tap_i.shift && bit_max) begin
          state_d = in_xfer;
        end
      end
      in_xfer: begin
        if (tap_i.update) begin
          state_d = in_idle;  // Abort, partial byte dropped
        end
      end
      default: state_d = in_idle;
    endcase
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q     <= in_idle;
      bit_cnt_q   <= '0;
      user_cnt_q  <= '0;
      space_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == in_idle) begin
        bit_cnt_q <= '0;
        if (sess_start) begin
          space_cnt_q <= rx_free_i;
        end
      end else if (shifting) begin
        bit_cnt_q <= bit_max ? '0 : bit_cnt_q + 1'b1;
        // Count byte only uses its low nibble
        if ((state_q == in_counts) && bit_max) begin
          user_cnt_q <= shreg_d[`JSP_CNT_W-1:0];
        end
        if (accept) begin
          user_cnt_q  <= user_cnt_q - 1'b1;
          space_cnt_q <= space_cnt_q - 1'b1;
        end
      end
    end
  end

  // Deserializer
  always_ff @(posedge tck_i) begin
    if (shifting) begin
      shreg_q <= shreg_d;
    end
  end

  assign rx_push_o = accept;
  assign rx_byte_o = shreg_d;  // Includes the bit on tdi this cycle

endmodule

`default_nettype wire

/* verilog/jsp_out_ctrl.sv */
// JTAG serial port output controller: status byte then tx FIFO bytes onto tdo

`timescale 1ns/100ps
`default_nettype none

`include "jsp_defines.svh"

module jsp_out_ctrl
  import jsp_jtag_pkg::*;
  import jsp_bus_pkg::*;
(
  input  wire            tck_i,
  input  wire            rst_i,
  input  jsp_tap_t       tap_i,
  input  wire            module_select_i,
  input  jsp_fifo_stat_t fifo_stat_i,
  input  jsp_byte_t      tx_head_i,   // Head of the tx FIFO
  output logic           tx_pop_o,
  output logic           tdo_o
);

  localparam int BIT_W = $clog2(`JSP_BYTE_W);

  jsp_out_state_t   state_q;
  jsp_out_state_t   state_d;
  logic [BIT_W-1:0] bit_cnt_q;   // Bits sent of the current byte
  logic             bit_max;     // Last bit of a byte on this edge
  jsp_cnt_t         word_cnt_q;  // tx bytes still owed to the host
  logic             word_left;
  jsp_byte_t        shreg_q;     // Parallel-load serializer, LSB out first
  logic             sess_start;
  logic             shift_en;    // Shift cycle inside a session
  logic             load_stat;
  logic             load_head;

  assign sess_start = tap_i.capture & module_select_i;
  assign bit_max    = (bit_cnt_q == BIT_W'(`JSP_BYTE_W - 1));
  assign word_left  = (word_cnt_q != '0);
  assign shift_en   = tap_i.shift & (state_q != out_idle);
  assign load_stat  = (state_q == out_idle) & sess_start;

  // Next byte replaces the shift at a byte boundary, popped one bit later
  assign load_head = shift_en & bit_max & word_left
                   & ((state_q == out_counts) | (state_q == out_xfer));

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      out_idle: begin
        if (sess_start) begin
          state_d = out_counts;
        end
      end
      out_counts: begin
        if (tap_i.update) begin
          state_d = out_idle;
        end else if (tap_i.shift && bit_max) begin
          state_d = out_rdack;
        end
      end
      out_rdack: begin
        if (tap_i.update) begin
          state_d = out_idle;
        end else if (tap_i.shift) begin
          state_d = out_xfer;  // Pop happens on this edge
        end
      end
      out_xfer: begin
        if (tap_i.update) begin
          state_d = out_idle;
        end else if (tap_i.shift && bit_max) begin
          state_d = out_rdack;
        end
      end
      default: state_d = out_idle;
    endcase
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= out_idle;
      bit_cnt_q  <= '0;
      word_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == out_idle) begin
        bit_cnt_q <= '0;
      end else if (shift_en) begin
        bit_cnt_q <= bit_max ? '0 : bit_cnt_q + 1'b1;
      end
      // Only bytes present at capture are sent
      if (load_stat) begin
        word_cnt_q <= fifo_stat_i.tx_avail;
      end else if (tx_pop_o) begin
        word_cnt_q <= word_cnt_q - 1'b1;
      end
    end
  end

  // Serializer, zeros fill in behind the data
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      shreg_q <= '0;
    end else if (load_stat) begin
      shreg_q <= fifo_stat_i;  // {tx_avail, rx_free}
    end else if (load_head) begin
      shreg_q <= tx_head_i;
    end else if (shift_en) begin
      shreg_q <= {1'b0, shreg_q[`JSP_BYTE_W-1:1]};
    end
  end

  // Read-acknowledge on the first bit of the loaded byte
  assign tx_pop_o = (state_q == out_rdack) & tap_i.shift & word_left;
  assign tdo_o    = shreg_q[0];

endmodule

`default_nettype wire

/* verilog/jsp_bus_unit.sv */
// JTAG serial port bus unit: rx and tx FIFOs behind a Wishbone slave

`timescale 1ns/100ps
`default_nettype none

`include "jsp_defines.svh"

module jsp_bus_unit
  import jsp_jtag_pkg::*;
  import jsp_bus_pkg::*;
(
  input  wire            tck_i,
  input  wire            rst_i,
  input  wire            rx_push_i,   // From the input controller
  input  jsp_byte_t      rx_byte_i,
  input  wire            tx_pop_i,    // From the output controller
  output jsp_byte_t      tx_head_o,
  output jsp_fifo_stat_t fifo_stat_o,
  input  jsp_wb_req_t    wb_req_i,
  output jsp_wb_rsp_t    wb_rsp_o
);

  jsp_byte_t rx_head;
  jsp_cnt_t  rx_count;
  jsp_cnt_t  tx_count;
  jsp_cnt_t  tx_free;
  logic      access;    // New transfer, not yet acked
  logic      wr_data;
  logic      rd_data;
  jsp_byte_t rd_mux;
  logic      ack_q;
  jsp_byte_t dat_q;

  assign access  = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign wr_data = access & wb_req_i.we & (wb_req_i.adr == JSP_ADR_DATA);
  assign rd_data = access & ~wb_req_i.we & (wb_req_i.adr == JSP_ADR_DATA);
  assign tx_free = `JSP_CNT_W'(`JSP_FIFO_DEPTH) - tx_count;

  // Host to software
  jsp_byte_fifo rx_fifo (
    .tck_i  (tck_i),
    .rst_i  (rst_i),
    .push_i (rx_push_i),
    .data_i (rx_byte_i),
    .pop_i  (rd_data),
    .data_o (rx_head),
    .count_o(rx_count)
  );

  // Software to host, a write to a full FIFO is dropped inside
  jsp_byte_fifo tx_fifo (
    .tck_i  (tck_i),
    .rst_i  (rst_i),
    .push_i (wr_data),
    .data_i (wb_req_i.dat),
    .pop_i  (tx_pop_i),
    .data_o (tx_head_o),
    .count_o(tx_count)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Register read and response
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (wb_req_i.adr == JSP_ADR_STATUS) begin
      rd_mux = {tx_free, rx_count};
    end else if (rx_count != '0) begin
      rd_mux = rx_head;
    end else begin
      rd_mux = '0;  // Empty rx reads as zero
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;  // Single-cycle pulse
    end
  end

  always_ff @(posedge tck_i) begin
    if (access && !wb_req_i.we) begin
      dat_q <= rd_mux;
    end
  end

  assign wb_rsp_o = '{ack: ack_q, dat: dat_q};

  // Levels for the JTAG side
  assign fifo_stat_o = '{tx_avail: tx_count,
                         rx_free:  `JSP_CNT_W'(`JSP_FIFO_DEPTH) - rx_count};

endmodule

`default_nettype wire

/* verilog/jtag_serial_port.sv */
// JTAG serial port top: input and output controllers joined to the bus unit

`timescale 1ns/100ps
`default_nettype none

module jtag_serial_port
  import jsp_jtag_pkg::*;
  import jsp_bus_pkg::*;
#(
  parameter bit JSP_MULTI_DEVICE = 1'b1
) (
  input  wire         tck_i,
  input  wire         rst_i,
  input  jsp_tap_t    tap_i,
  input  wire         module_select_i,
  input  wire         tdi_i,
  output logic        tdo_o,
  input  jsp_wb_req_t wb_req_i,
  output jsp_wb_rsp_t wb_rsp_o
);

  logic           rx_push;    // One pulse per accepted host byte
  jsp_byte_t      rx_byte;
  logic           tx_pop;     // Read-acknowledge from the output side
  jsp_byte_t      tx_head;
  jsp_fifo_stat_t fifo_stat;

  jsp_in_ctrl #(
    .JSP_MULTI_DEVICE(JSP_MULTI_DEVICE)
  ) u_in_ctrl (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .tap_i          (tap_i),
    .module_select_i(module_select_i),
    .tdi_i          (tdi_i),
    .rx_free_i      (fifo_stat.rx_free),
    .rx_push_o      (rx_push),
    .rx_byte_o      (rx_byte)
  );

  jsp_out_ctrl u_out_ctrl (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .tap_i          (tap_i),
    .module_select_i(module_select_i),
    .fifo_stat_i    (fifo_stat),
    .tx_head_i      (tx_head),
    .tx_pop_o       (tx_pop),
    .tdo_o          (tdo_o)
  );

  jsp_bus_unit u_bus_unit (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .rx_push_i  (rx_push),
    .rx_byte_i  (rx_byte),
    .tx_pop_i   (tx_pop),
    .tx_head_o  (tx_head),
    .fifo_stat_o(fifo_stat),
    .wb_req_i   (wb_req_i),
    .wb_rsp_o   (wb_rsp_o)
  );

endmodule

`default_nettype wire

/* sim/tb_jtag_serial_port.sv */
// JTAG serial port testbench driving directed JTAG sessions and Wishbone transfers

`timescale 1ns/100ps
`default_nettype none

`include "jsp_defines.svh"

module tb_jtag_serial_port
  import jsp_jtag_pkg::*;
  import jsp_bus_pkg::*;
();

  localparam int CYCLE_LIMIT = 4000;  // Whole run takes about 1100 cycles
  localparam int ACK_LIMIT   = 8;     // Ack is due one cycle after the request
  localparam int DEPTH       = `JSP_FIFO_DEPTH;

  localparam jsp_tap_t TAP_IDLE    = '{capture: 1'b0, shift: 1'b0, update: 1'b0};
  localparam jsp_tap_t TAP_CAPTURE = '{capture: 1'b1, shift: 1'b0, update: 1'b0};
  localparam jsp_tap_t TAP_SHIFT   = '{capture: 1'b0, shift: 1'b1, update: 1'b0};
  localparam jsp_tap_t TAP_UPDATE  = '{capture: 1'b0, shift: 1'b0, update: 1'b1};

  logic        tck = 1'b0;
  logic        rst;
  jsp_tap_t    tap;
  logic        module_select;
  logic        tdi;
  logic        tdo;
  jsp_wb_req_t wb_req;
  jsp_wb_rsp_t wb_rsp;
  int unsigned cycle_cnt = 0;
  logic [31:0] rng_state = 32'h4eacbe34;
  jsp_byte_t   host_out[$];  // Bytes the host shifts in
  jsp_byte_t   host_in[$];   // Bytes the host shifted out
  jsp_byte_t   exp_q[$];     // Expected data with zeros past its end

  jtag_serial_port #(
    .JSP_MULTI_DEVICE(1'b1)
  ) DUT (
    .tck_i          (tck),
    .rst_i          (rst),
    .tap_i          (tap),
    .module_select_i(module_select),
    .tdi_i          (tdi),
    .tdo_o          (tdo),
    .wb_req_i       (wb_req),
    .wb_rsp_o       (wb_rsp)
  );

  always #50 tck = ~tck;  // 100 ns period

  // Watchdog
  always @(posedge tck) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and random data
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input jsp_byte_t got, input jsp_byte_t exp);
    if (got !== exp) begin
      $display("** Error %s got 0x%02h expected 0x%02h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_stat(input string name, input jsp_fifo_stat_t got,
                            input jsp_fifo_stat_t exp);
    if (got !== exp) begin
      $display("** Error %s got 0x%02h expected 0x%02h (tx_avail 0x%h, rx_free 0x%h)",
               name, got, exp, exp.tx_avail, exp.rx_free);
      abort_run();
    end
  endtask

  // Status byte as the host sees it
  function automatic jsp_fifo_stat_t make_stat(input int tx_avail, input int rx_free);
    return '{tx_avail: jsp_cnt_t'(tx_avail), rx_free: jsp_cnt_t'(rx_free)};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic next_byte(output jsp_byte_t b);
    rng_state = xorshift32(rng_state);
    b         = rng_state[15:8];
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone master
  ////////////////////////////////////////////////////////////////////////////

  task automatic wb_xfer(input logic we, input logic adr, input jsp_byte_t wdat,
                         output jsp_byte_t rdat);
    int waited;
    waited = 0;
    @(negedge tck);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    @(negedge tck);
    while (wb_rsp.ack !== 1'b1) begin
      waited++;
      if (waited > ACK_LIMIT) begin
        $display("No Wishbone ack within %0d cycles", ACK_LIMIT);
        abort_run();
      end
      @(negedge tck);
    end
    rdat   = wb_rsp.dat;  // Held with ack
    wb_req = '0;
  endtask

  task automatic wb_write(input logic adr, input jsp_byte_t dat);
    jsp_byte_t unused;
    wb_xfer(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic adr, output jsp_byte_t dat);
    wb_xfer(1'b0, adr, '0, dat);
  endtask

  // Status register holds tx free high, rx available low
  task automatic check_status(input int tx_free, input int rx_avail);
    jsp_byte_t got;
    wb_read(JSP_ADR_STATUS, got);
    check_byte("wb_rsp_o.dat status", got, {jsp_cnt_t'(tx_free), jsp_cnt_t'(rx_avail)});
  endtask

  task automatic expect_rx(input int n);
    jsp_byte_t got;
    int        k;
    for (k = 0; k < n; k++) begin
      wb_read(JSP_ADR_DATA, got);
      check_byte("wb_rsp_o.dat", got, exp_q[k]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // JTAG host
  ////////////////////////////////////////////////////////////////////////////

  task automatic shift_bit(input logic bit_in, output logic bit_out);
    @(negedge tck);
    tap     = TAP_SHIFT;
    tdi     = bit_in;
    bit_out = tdo;  // Bit that leaves on the coming edge
  endtask

  task automatic pause(input int cycles);
    repeat (cycles) begin
      @(negedge tck);
      tap = TAP_IDLE;  // Shift low
    end
  endtask

  task automatic start_session();
    @(negedge tck);
    module_select = 1'b1;
    tap           = TAP_CAPTURE;
  endtask

  task automatic end_session();
    @(negedge tck);
    tap = TAP_UPDATE;
    tdi = 1'b0;
    @(negedge tck);
    tap           = TAP_IDLE;
    module_select = 1'b0;
  endtask

  // Start bit, count byte, host_out bytes, then an optional partial byte
  task automatic jtag_write_session(input jsp_byte_t count_byte, input int tail_bits);
    logic unused;
    int   i;
    int   k;
    start_session();
    shift_bit(1'b0, unused);  // Bypass bits of other devices
    shift_bit(1'b0, unused);
    shift_bit(1'b1, unused);  // Start bit
    for (i = 0; i < `JSP_BYTE_W; i++) begin
      shift_bit(count_byte[i], unused);
    end
    pause(2);
    for (k = 0; k < host_out.size(); k++) begin
      for (i = 0; i < `JSP_BYTE_W; i++) begin
        shift_bit(host_out[k][i], unused);
      end
    end
    for (i = 0; i < tail_bits; i++) begin
      shift_bit(1'b1, unused);
    end
    end_session();
  endtask

  // Status byte, then n_bytes into host_in, then an optional partial byte
  task automatic jtag_read_session(input int n_bytes, input int tail_bits,
                                   output jsp_fifo_stat_t stat);
    jsp_byte_t shift_in;
    int        i;
    int        k;
    host_in.delete();
    start_session();
    for (i = 0; i < `JSP_BYTE_W; i++) begin
      shift_bit(1'b0, shift_in[i]);
    end
    stat = jsp_fifo_stat_t'(shift_in);
    pause(2);
    for (k = 0; k < n_bytes; k++) begin
      for (i = 0; i < `JSP_BYTE_W; i++) begin
        shift_bit(1'b0, shift_in[i]);
      end
      host_in.push_back(shift_in);
    end
    for (i = 0; i < tail_bits; i++) begin
      shift_bit(1'b0, shift_in[0]);
    end
    end_session();
  endtask

  task automatic check_host_in();
    jsp_byte_t exp;
    int        k;
    for (k = 0; k < host_in.size(); k++) begin
      exp = (k < exp_q.size()) ? exp_q[k] : '0;
      check_byte($sformatf("tdo_o byte %0d", k), host_in[k], exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    jsp_fifo_stat_t stat;
    check_byte("wb_rsp_o.ack", jsp_byte_t'(wb_rsp.ack), 8'h00);
    check_byte("tdo_o", jsp_byte_t'(tdo), 8'h00);
    check_status(DEPTH, 0);
    exp_q.delete();
    jtag_read_session(3, 0, stat);
    check_stat("tdo_o status byte", stat, make_stat(0, DEPTH));
    check_host_in();  // All zero
  endtask

  task automatic test_bus_to_host();
    jsp_fifo_stat_t stat;
    exp_q = '{8'h5a, 8'hc3, 8'h17};
    foreach (exp_q[k]) begin
      wb_write(JSP_ADR_DATA, exp_q[k]);
    end
    check_status(DEPTH - 3, 0);
    jtag_read_session(4, 0, stat);
    check_stat("tdo_o status byte", stat, make_stat(3, DEPTH));
    check_host_in();
    check_status(DEPTH, 0);
    // A byte written on the capture edge waits for the next session
    exp_q.delete();
    fork
      jtag_read_session(1, 0, stat);
      wb_write(JSP_ADR_DATA, 8'h6b);
    join
    check_stat("tdo_o status byte", stat, make_stat(0, DEPTH));
    check_host_in();
    exp_q = '{8'h6b};
    jtag_read_session(2, 0, stat);
    check_stat("tdo_o status byte", stat, make_stat(1, DEPTH));
    check_host_in();
    check_status(DEPTH, 0);
  endtask

  task automatic test_host_to_bus();
    host_out = '{8'ha5, 8'h3c, 8'he1};
    exp_q    = host_out;
    jtag_write_session(8'ha3, 0);  // High nibble ignored
    check_status(DEPTH, 3);
    expect_rx(3);
    check_status(DEPTH, 0);
  endtask

  task automatic test_count_limits();
    jsp_fifo_stat_t stat;
    jsp_byte_t      b;
    int             k;
    // User count 2 while the host offers 4
    host_out = '{8'h11, 8'h22, 8'h33, 8'h44};
    exp_q    = host_out;
    jtag_write_session(8'h02, 0);
    check_status(DEPTH, 2);
    expect_rx(2);
    wb_read(JSP_ADR_DATA, b);
    check_byte("wb_rsp_o.dat empty", b, 8'h00);
    // Space count stops at the depth
    host_out.delete();
    for (k = 0; k < DEPTH + 2; k++) begin
      host_out.push_back(jsp_byte_t'(8'h80 + k));
    end
    exp_q = host_out;
    jtag_write_session(8'h0f, 0);
    check_status(DEPTH, DEPTH);
    // Room freed by software after capture stays unused in this session
    host_out = '{8'hee, 8'hdd};
    fork
      jtag_write_session(8'h02, 0);
      expect_rx(2);
    join
    repeat (2) begin
      exp_q.delete(0);
    end
    check_status(DEPTH, DEPTH - 2);
    jtag_read_session(0, 0, stat);
    check_stat("tdo_o status byte", stat, make_stat(0, 2));
    expect_rx(DEPTH - 2);
    check_status(DEPTH, 0);
    // Ninth bus write finds the tx FIFO full
    exp_q.delete();
    for (k = 0; k < DEPTH + 1; k++) begin
      next_byte(b);
      wb_write(JSP_ADR_DATA, b);
      if (k < DEPTH) begin
        exp_q.push_back(b);
      end
    end
    check_status(0, 0);
    jtag_read_session(DEPTH + 1, 0, stat);
    check_stat("tdo_o status byte", stat, make_stat(DEPTH, DEPTH));
    check_host_in();
    check_status(DEPTH, 0);
  endtask

  task automatic test_session_abort();
    jsp_fifo_stat_t stat;
    // Update arrives halfway through the second host byte
    host_out = '{8'h9e};
    jtag_write_session(8'h03, 4);
    check_status(DEPTH, 1);
    exp_q = '{8'hc1, 8'hc2, 8'hc3, 8'hc4};
    foreach (exp_q[k]) begin
      wb_write(JSP_ADR_DATA, exp_q[k]);
    end
    // First bit of the second byte already pops it
    jtag_read_session(1, 3, stat);
    check_stat("tdo_o status byte", stat, make_stat(4, DEPTH - 1));
    check_host_in();
    check_status(DEPTH - 2, 1);
    exp_q = '{8'hc3, 8'hc4};
    jtag_read_session(3, 0, stat);
    check_stat("tdo_o status byte", stat, make_stat(2, DEPTH - 1));
    check_host_in();
    exp_q = '{8'h9e};
    expect_rx(1);
    check_status(DEPTH, 0);
  endtask

  // Host bytes echoed by software and read back by the host
  task automatic test_random_round_trip();
    jsp_fifo_stat_t stat;
    jsp_byte_t      b;
    int             n;
    int             k;
    repeat (2) begin
      next_byte(b);
      n = int'(b[2:0]) + 1;  // 1 to 8 bytes
      host_out.delete();
      for (k = 0; k < n; k++) begin
        next_byte(b);
        host_out.push_back(b);
      end
      exp_q = host_out;
      jtag_write_session(jsp_byte_t'(n), 0);
      check_status(DEPTH, n);
      expect_rx(n);
      foreach (exp_q[i]) begin
        wb_write(JSP_ADR_DATA, exp_q[i]);
      end
      check_status(DEPTH - n, 0);
      jtag_read_session(n + 1, 0, stat);
      check_stat("tdo_o status byte", stat, make_stat(n, DEPTH));
      check_host_in();
      check_status(DEPTH, 0);
    end
  endtask

  initial begin
    rst           = 1'b1;
    tap           = TAP_IDLE;
    module_select = 1'b0;
    tdi           = 1'b0;
    wb_req        = '0;
    repeat (5) @(negedge tck);
    rst = 1'b0;
    test_reset_state();
    test_bus_to_host();
    test_host_to_bus();
    test_count_limits();
    test_session_abort();
    test_random_round_trip();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* jtag_serial_port.f */
+incdir+verilog
verilog/jsp_jtag_pkg.sv
verilog/jsp_bus_pkg.sv
verilog/jsp_byte_fifo.sv
verilog/jsp_in_ctrl.sv
verilog/jsp_out_ctrl.sv
verilog/jsp_bus_unit.sv
verilog/jtag_serial_port.sv
sim/tb_jtag_serial_port.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the JTAG serial port testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_jtag_serial_port \
  -f jtag_serial_port.f -o tb_jtag_serial_port
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_jtag_serial_port > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

grep -q "Verification failed" "$LOG"
grep_status=$?
if [ $grep_status -eq 0 ]; then
  exit 1
elif [ $grep_status -ne 1 ]; then
  echo "Could not search $LOG"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
